/* rtl/ltx_defs.svh */
/* ltx link sizes
   lane width and word FIFO depth shared by package and RTL */

`ifndef LTX_DEFS_SVH
`define LTX_DEFS_SVH

// ####################
// lane
// ####################

`define LTX_N 16            // lane width in bits, a word is twice this

// ####################
// buffering
// ####################

`define LTX_FIFO_DEPTH 4    // word FIFO entries, keep a power of two

`endif

/* rtl/ltx_fifo.sv */
/* ltx word FIFO
   register array between intake and IO block, push and take in one cycle */

`timescale 1ns/1ns

`include "ltx_defs.svh"

module ltx_fifo
   import ltx_pkg::*;
(
   input  logic      io_clk,
   input  logic      io_nreset,

   // write side
   input  logic      push,
   input  ltx_word_t push_word,
   output logic      full,

   // read side
   output logic      head_valid,    // head_word holds the oldest word
   output ltx_word_t head_word,
   input  logic      take           // pop the head
);

   localparam int DEPTH = `LTX_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   ltx_word_t   mem [DEPTH];        // payload, no reset needed
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;            // 0..DEPTH
   logic          do_push;
   logic          do_take;

   // guard against misuse at the edges
   assign do_push = push && !full;
   assign do_take = take && head_valid;

   // ####################
   // storage
   // ####################

   always_ff @(posedge io_clk) begin
      if (do_push)
         mem[wr_ptr] <= push_word;
   end

   assign head_word = mem[rd_ptr];  // valid only with head_valid

   // ####################
   // pointers and count
   // ####################

   // pointers wrap by overflow, depth is a power of two
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_take)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_take})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // none, or both at once
         endcase
      end
   end

   // flags straight from the count flops
   assign full       = (count == DEPTH[AW:0]);
   assign head_valid = (count != '0);

endmodule

/* rtl/ltx_intake.sv */
/* ltx intake
   four-phase req/ack receiver, pushes one word per handshake into the FIFO */

`timescale 1ns/1ns

module ltx_intake
   import ltx_pkg::*;
(
   input  logic      io_clk,
   input  logic      io_nreset,

   // core side
   input  logic      core_req,      // word offered, packet stable
   input  ltx_word_t core_packet,
   output logic      core_ack,

   // FIFO side
   output logic      push,          // write strobe
   output ltx_word_t push_word,
   input  logic      full           // no space, hold off the ack
);

   ltx_intake_state_t state;
   ltx_intake_state_t state_nxt;
   logic              accept;       // req seen with room in FIFO

   // ####################
   // handshake FSM
   // ####################

   // word taken only from idle, and only with space
   assign accept = (state == st_idle) && core_req && !full;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (accept)
               state_nxt = st_ack;        // ack rises next cycle
         end
         st_ack: begin
            if (!core_req)
               state_nxt = st_release;    // core let go, drop ack
         end
         st_release: begin
            state_nxt = st_idle;          // ack is low now, rearm
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   // ####################
   // outputs
   // ####################

   // ack is a decode of the state flops, so glitch free
   assign core_ack = (state == st_ack);

   // push lands in the FIFO on the same edge that raises ack
   // packet is held stable by the core while req is high
   assign push      = accept;
   assign push_word = core_packet;

   // full only stalls in idle
   // once acked the word is already in the FIFO

endmodule

/* rtl/ltx_pkg.sv */
/* ltx link types
   word, lane half, output mode and intake handshake phases */

`include "ltx_defs.svh"

package ltx_pkg;

   // one packet word from the core
   typedef logic [2*`LTX_N-1:0] ltx_word_t;

   // one half of a word as it appears on the lane
   typedef logic [`LTX_N-1:0] ltx_lane_t;

   // lane signalling
   typedef enum logic {
      ltx_sdr,              // halves on consecutive cycles
      ltx_ddr               // both halves within one cycle
   } ltx_mode_t;

   // four-phase req/ack phases on the core side
   typedef enum logic [1:0] {
      st_idle,              // waiting for req, or for FIFO space
      st_ack,               // ack high, waiting for req to drop
      st_release            // ack dropped, one cycle before next req
   } ltx_intake_state_t;

endpackage

/* rtl/ltx_top.sv */
/* ltx transmit top
   core intake, word FIFO and lane IO block of the chip-to-chip link */

`timescale 1ns/1ns

module ltx_top
   import ltx_pkg::*;
(
   input  logic      io_clk,
   input  logic      io_nreset,      // async, active low

   // config, static per test
   input  ltx_mode_t mode,
   input  logic      lsbfirst,

   // core side
   input  logic      core_req,
   input  ltx_word_t core_packet,
   output logic      core_ack,

   // lane side
   output ltx_lane_t tx_packet,
   output logic      tx_access,
   input  logic      tx_wait
);

   // intake to FIFO
   logic      push;
   ltx_word_t push_word;
   logic      full;

   // FIFO to IO block
   logic      head_valid;
   ltx_word_t head_word;
   logic      take;

   ltx_intake ltx_intake_i (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .core_req    (core_req),
      .core_packet (core_packet),
      .core_ack    (core_ack),
      .push        (push),
      .push_word   (push_word),
      .full        (full)
   );

   ltx_fifo ltx_fifo_i (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .push       (push),
      .push_word  (push_word),
      .full       (full),
      .head_valid (head_valid),
      .head_word  (head_word),
      .take       (take)
   );

   ltx_tx_io ltx_tx_io_i (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .mode       (mode),
      .lsbfirst   (lsbfirst),
      .head_valid (head_valid),
      .head_word  (head_word),
      .take       (take),
      .tx_packet  (tx_packet),
      .tx_access  (tx_access),
      .tx_wait    (tx_wait)
   );

endmodule

/* rtl/ltx_tx_io.sv */
/* ltx transmit IO
   orders word halves by lsbfirst and drives them on the lane as SDR or DDR */

`timescale 1ns/1ns

`include "ltx_defs.svh"

module ltx_tx_io
   import ltx_pkg::*;
(
   input  logic      io_clk,
   input  logic      io_nreset,

   // static config
   input  ltx_mode_t mode,
   input  logic      lsbfirst,      // low half goes out first

   // FIFO side
   input  logic      head_valid,
   input  ltx_word_t head_word,
   output logic      take,          // one cycle, loads and pops the head

   // lane side
   output ltx_lane_t tx_packet,
   output logic      tx_access,
   input  logic      tx_wait        // partner hold-off
);

   localparam int N = `LTX_N;

   ltx_lane_t first_half;           // head word, reordered
   ltx_lane_t second_half;
   ltx_lane_t rise_q;               // posedge lane register
   ltx_lane_t second_q;             // second half held past the pop
   ltx_lane_t fall_q;               // negedge lane register, DDR only
   logic      sdr_pending;          // SDR second half still owed
   logic      access_q;

   // ####################
   // half selector
   // ####################

   assign first_half  = lsbfirst ? head_word[N-1:0]   : head_word[2*N-1:N];
   assign second_half = lsbfirst ? head_word[2*N-1:N] : head_word[N-1:0];

   // no load while the SDR pair is split across cycles
   assign take = head_valid && !tx_wait && !sdr_pending;

   // ####################
   // SDR sequencer
   // ####################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         sdr_pending <= 1'b0;
         access_q    <= 1'b0;
      end else begin
         sdr_pending <= take && (mode == ltx_sdr);  // cleared after one cycle
         access_q    <= take || sdr_pending;        // 1 cycle DDR, 2 cycles SDR
      end
   end

   // rising edge data, first half on load, second half on the next cycle
   // in DDR this is the high phase half
   always_ff @(posedge io_clk) begin
      if (take) begin
         rise_q   <= first_half;
         second_q <= second_half;
      end else if (sdr_pending) begin
         rise_q   <= second_q;
      end
   end

   // ####################
   // DDR output stage
   // ####################

   // low phase half, captured mid cycle from the held copy
   always_ff @(negedge io_clk) begin
      fall_q <= second_q;
   end

   // clock phase mux stands in for the output DDR cell
   always_comb begin
      if (mode == ltx_ddr)
         tx_packet = io_clk ? rise_q : fall_q;
      else
         tx_packet = rise_q;
   end

   assign tx_access = access_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the ltx transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f \
   --top-module ltx_tb \
   -Mdir obj_dir -o Vltx_tb

# tee keeps the log even when the run stops early
./obj_dir/Vltx_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "tests failed" sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

if ! grep -qx "all tests passed" sim.log; then
   echo "simulation ended without a result line, see sim.log"
   exit 1
fi

echo "simulation clean"

/* sim/ltx_sva.sv */
/* ltx assertions
   core handshake order, reset values and SDR half pairing */

`timescale 1ns/1ns

module ltx_sva
   import ltx_pkg::*;
(
   input logic      io_clk,
   input logic      io_nreset,
   input ltx_mode_t mode,
   input logic      core_req,
   input logic      core_ack,
   input logic      push,
   input logic      full,
   input logic      take,
   input logic      tx_access
);

   int fail_count = 0;      // assertion failures so far

   // ####################
   // core handshake
   // ####################

   ack_rise: assert property (@(posedge io_clk) disable iff (!io_nreset)
      $rose(core_ack) |-> $past(core_req))
      else begin fail_count++; $error("core_ack rose without core_req"); end

   ack_fall: assert property (@(posedge io_clk) disable iff (!io_nreset)
      $fell(core_ack) |-> !$past(core_req))
      else begin fail_count++; $error("core_ack fell while core_req high"); end

   req_rise: assert property (@(posedge io_clk) disable iff (!io_nreset)
      $rose(core_req) |-> !core_ack)
      else begin fail_count++; $error("core_req rose before core_ack dropped"); end

   // word lands in the FIFO on the edge that raises ack
   push_ack: assert property (@(posedge io_clk) disable iff (!io_nreset)
      push |=> core_ack)
      else begin fail_count++; $error("core_ack did not follow a push"); end

   // no new ack while the FIFO has no room
   full_hold: assert property (@(posedge io_clk) disable iff (!io_nreset)
      full && !core_ack |=> !core_ack)
      else begin fail_count++; $error("core_ack raised while the FIFO was full"); end

   // ####################
   // reset and lane
   // ####################

   reset_quiet: assert property (@(posedge io_clk)
      !io_nreset |-> !core_ack && !tx_access)
      else begin fail_count++; $error("core_ack or tx_access high in reset"); end

   // SDR halves back to back, no load in between
   sdr_pair: assert property (@(posedge io_clk) disable iff (!io_nreset)
      take && (mode == ltx_sdr) |=> tx_access && !take ##1 tx_access)
      else begin fail_count++; $error("SDR word not sent on two cycles"); end

   ddr_one: assert property (@(posedge io_clk) disable iff (!io_nreset)
      take && (mode == ltx_ddr) |=> tx_access)
      else begin fail_count++; $error("DDR word without tx_access"); end

endmodule

/* sim/ltx_tb.sv */
/* ltx testbench
   file-driven core handshakes, lane monitor and watchdog for the transmit link */

`timescale 1ns/1ns

`include "ltx_defs.svh"

module ltx_tb
   import ltx_pkg::*;
();

   localparam int MAX_REC        = 64;
   localparam int RESET_CYCLES   = 8;
   localparam int CYCLES_PER_REC = 40;      // watchdog budget per record
   localparam int WAIT_FILL      = 40;      // hold long enough to fill the FIFO
   localparam int DEPTH          = `LTX_FIFO_DEPTH;

   logic      io_clk;
   logic      io_nreset;
   ltx_mode_t mode;
   logic      lsbfirst;
   logic      core_req;
   ltx_word_t core_packet;
   logic      core_ack;
   ltx_lane_t tx_packet;
   logic      tx_access;
   logic      tx_wait;

   // records from the tests file
   string     rec_name   [MAX_REC];
   ltx_mode_t rec_mode   [MAX_REC];
   logic      rec_lsb    [MAX_REC];
   ltx_word_t rec_word   [MAX_REC];
   int        rec_wait   [MAX_REC];
   ltx_lane_t rec_first  [MAX_REC];      // lane order
   ltx_lane_t rec_second [MAX_REC];
   int        rec_err    [MAX_REC];

   int   n_rec      = 0;
   int   n_pushed   = 0;                 // acked by the intake
   int   n_done     = 0;                 // both halves seen on the lane
   int   err_count  = 0;
   int   fail_tests = 0;
   int   held_acks  = 0;
   int   cyc        = 0;                 // posedge count, wait driver only
   int   wait_end   = 0;                 // tx_wait high while cyc below this
   int   seed       = 32'h05e0_4da5;
   logic loaded     = 1'b0;

   ltx_top ltx_top_i (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .mode        (mode),
      .lsbfirst    (lsbfirst),
      .core_req    (core_req),
      .core_packet (core_packet),
      .core_ack    (core_ack),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .tx_wait     (tx_wait)
   );

   bind ltx_top ltx_sva ltx_sva_i (
      .io_clk    (io_clk),
      .io_nreset (io_nreset),
      .mode      (mode),
      .core_req  (core_req),
      .core_ack  (core_ack),
      .push      (push),
      .full      (full),
      .take      (take),
      .tx_access (tx_access)
   );

   // ####################
   // compare helpers
   // ####################

   function automatic string test_name(input int idx);
      if (idx < 0)
         return "startup";
      return rec_name[idx];
   endfunction

   task automatic note_error(input int idx);
      err_count++;
      if (idx >= 0)
         rec_err[idx]++;
   endtask

   task automatic check_lane(input int idx, input string what, input ltx_lane_t exp,
                             input ltx_lane_t got);
      if (got !== exp) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name(idx), what, exp, got);
         note_error(idx);
      end
   endtask

   task automatic check_bit(input int idx, input string what, input logic exp, input logic got);
      if (got !== exp) begin
         $display("MISMATCH %s %s: expected %b, actual %b", test_name(idx), what, exp, got);
         note_error(idx);
      end
   endtask

   // ####################
   // stimulus
   // ####################

   task automatic load_tests();
      int        fd;
      int        got;
      int        lsb;
      int        wlen;
      string     line;
      string     name;
      string     mstr;
      ltx_word_t word;
      ltx_lane_t e0;
      ltx_lane_t e1;
      fd = $fopen("sim/ltx_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test records in sim/ltx_tests.txt");
         note_error(-1);
         return;
      end
      while (!$feof(fd) && n_rec < MAX_REC) begin
         line = "";
         got  = $fgets(line, fd);
         if (got == 0 || line.len() < 2 || line.substr(0, 0) == "#")
            continue;                     // blank or column notes
         got = $sscanf(line, "%s %s %d %h %d %h %h", name, mstr, lsb, word, wlen, e0, e1);
         if (got != 7) begin
            $display("malformed test record: %s", line);
            note_error(-1);
            continue;
         end
         rec_name[n_rec]   = name;
         rec_mode[n_rec]   = (mstr == "ddr") ? ltx_ddr : ltx_sdr;
         rec_lsb[n_rec]    = lsb[0];
         rec_word[n_rec]   = word;
         rec_wait[n_rec]   = wlen;
         rec_first[n_rec]  = e0;
         rec_second[n_rec] = e1;
         rec_err[n_rec]    = 0;
         n_rec++;
      end
      $fclose(fd);
   endtask

   // one four-phase cycle, all edges on negedge
   task automatic run_handshake(input int idx);
      int gap;
      check_bit(idx, "core_ack low before req", 1'b0, core_ack);
      core_packet = rec_word[idx];
      core_req    = 1'b1;
      @(negedge io_clk);
      if (core_ack !== 1'b1) begin        // late ack, FIFO must be full
         held_acks++;
         check_bit(idx, "ack held only with FIFO full", 1'b1, (n_pushed - n_done >= DEPTH));
      end
      while (core_ack !== 1'b1)
         @(negedge io_clk);
      n_pushed++;
      core_req = 1'b0;
      @(negedge io_clk);
      check_bit(idx, "core_ack drop after req drop", 1'b0, core_ack);
      while (core_ack !== 1'b0)
         @(negedge io_clk);
      gap = 1 + ($random(seed) & 3);      // one cycle covers st_release
      repeat (gap) @(negedge io_clk);
   endtask

   initial begin
      io_clk = 1'b0;
      forever #2 io_clk = ~io_clk;       // 4 ns period
   end

   // tx_wait from wait_end, decided at posedge and driven at negedge
   initial begin : wait_driver
      logic wait_hi;
      tx_wait = 1'b0;
      forever begin
         @(posedge io_clk);
         wait_hi = (cyc < wait_end);
         cyc++;
         @(negedge io_clk);
         tx_wait = wait_hi;
      end
   end

   // ####################
   // lane monitor
   // ####################

   task automatic finish_test(input int idx);
      if (rec_err[idx] == 0) begin
         $display("test %-12s ok", rec_name[idx]);
      end else begin
         $display("test %-12s FAILED, %0d errors", rec_name[idx], rec_err[idx]);
         fail_tests++;
      end
      n_done++;
   endtask

   initial begin : lane_monitor
      ltx_lane_t got0;
      int        half;
      half = 0;
      forever begin
         @(posedge io_clk);
         #1;                              // lane settled, high phase
         if (tx_access === 1'b1) begin
            if (n_done >= n_pushed) begin
               $display("lane access at %0t with no word outstanding", $time);
               note_error(-1);
            end else if (mode == ltx_ddr) begin
               got0 = tx_packet;
               @(negedge io_clk);
               #1;                        // low phase half
               check_lane(n_done, "first half", rec_first[n_done], got0);
               check_lane(n_done, "second half", rec_second[n_done], tx_packet);
               finish_test(n_done);
            end else if (half == 0) begin
               got0 = tx_packet;
               half = 1;
            end else begin
               check_lane(n_done, "first half", rec_first[n_done], got0);
               check_lane(n_done, "second half", rec_second[n_done], tx_packet);
               half = 0;
               finish_test(n_done);
            end
         end else if (half == 1) begin     // SDR pair split
            check_bit(n_done, "tx_access for SDR second half", 1'b1, tx_access);
            half = 0;
            finish_test(n_done);
         end
      end
   end

   // ####################
   // main sequence
   // ####################

   initial begin : main_seq
      logic fill_expected;
      int   sva_fails;
      io_nreset     = 1'b0;
      mode          = ltx_sdr;
      lsbfirst      = 1'b0;
      core_req      = 1'b0;
      core_packet   = '0;
      fill_expected = 1'b0;
      load_tests();
      loaded = 1'b1;
      repeat (RESET_CYCLES) begin
         @(negedge io_clk);
         check_bit(-1, "core_ack in reset", 1'b0, core_ack);
         check_bit(-1, "tx_access in reset", 1'b0, tx_access);
      end
      io_nreset = 1'b1;
      repeat (4) begin                    // quiet until first req
         @(negedge io_clk);
         check_bit(-1, "core_ack after reset", 1'b0, core_ack);
         check_bit(-1, "tx_access after reset", 1'b0, tx_access);
      end
      for (int i = 0; i < n_rec; i++) begin
         if (i == 0 || rec_mode[i] != mode || rec_lsb[i] != lsbfirst) begin
            while (n_done != n_pushed)    // config only changes when drained
               @(negedge io_clk);
            @(negedge io_clk);
            mode     = rec_mode[i];
            lsbfirst = rec_lsb[i];
            @(negedge io_clk);
         end
         if (rec_wait[i] > 0) begin
            if (rec_wait[i] >= WAIT_FILL)
               fill_expected = 1'b1;
            if (cyc + rec_wait[i] > wait_end)
               wait_end = cyc + rec_wait[i];
            @(negedge io_clk);            // tx_wait up around the push
         end
         run_handshake(i);
      end
      while (n_done != n_pushed)
         @(negedge io_clk);
      repeat (4) @(negedge io_clk);
      check_bit(-1, "tx_access idle at end", 1'b0, tx_access);
      if (fill_expected)
         check_bit(-1, "core_ack withheld on full FIFO", 1'b1, held_acks != 0);
      sva_fails = ltx_top_i.ltx_sva_i.fail_count;
      $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
               n_done, n_done - fail_tests, fail_tests, err_count, sva_fails);
      if (err_count == 0 && sva_fails == 0 && n_rec > 0 && n_done == n_rec)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // run length bound from the record count
   initial begin : watchdog
      wait (loaded);
      #((n_rec * CYCLES_PER_REC + RESET_CYCLES) * 4);
      $display("timeout, run did not end within %0d cycles",
               n_rec * CYCLES_PER_REC + RESET_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

/* sim/ltx_tests.txt */
# columns: name mode(sdr|ddr) lsbfirst word wait_cycles first_half second_half
# hex word and halves, halves in lane order, wait_cycles holds tx_wait from the push
sdr_msb_a  sdr 0 12345678 0 1234 5678
sdr_msb_b  sdr 0 deadbeef 0 dead beef
sdr_msb_c  sdr 0 0000ffff 0 0000 ffff
sdr_lsb_a  sdr 1 12345678 0 5678 1234
sdr_lsb_b  sdr 1 cafef00d 0 f00d cafe
sdr_wait_a sdr 1 a5a55a5a 6 5a5a a5a5
sdr_wait_b sdr 1 0f0ff0f0 0 f0f0 0f0f
sdr_wait_c sdr 1 13572468 0 2468 1357
ddr_msb_a  ddr 0 89abcdef 0 89ab cdef
ddr_msb_b  ddr 0 ffff0000 0 ffff 0000
ddr_lsb_a  ddr 1 89abcdef 0 cdef 89ab
ddr_lsb_b  ddr 1 01234567 0 4567 0123
ddr_wait_a ddr 1 11112222 5 2222 1111
ddr_wait_b ddr 1 33334444 0 4444 3333
ddr_fill_a ddr 0 a0a1a2a3 48 a0a1 a2a3
ddr_fill_b ddr 0 b0b1b2b3 0 b0b1 b2b3
ddr_fill_c ddr 0 c0c1c2c3 0 c0c1 c2c3
ddr_fill_d ddr 0 d0d1d2d3 0 d0d1 d2d3
ddr_fill_e ddr 0 e0e1e2e3 0 e0e1 e2e3
ddr_fill_f ddr 0 f0f1f2f3 0 f0f1 f2f3
sdr_fill_a sdr 1 10203040 48 3040 1020
sdr_fill_b sdr 1 50607080 0 7080 5060
sdr_fill_c sdr 1 90a0b0c0 0 b0c0 90a0
sdr_fill_d sdr 1 d0e0f000 0 f000 d0e0
sdr_fill_e sdr 1 12121313 0 1313 1212

/* verilog.f */
+incdir+rtl
rtl/ltx_pkg.sv
rtl/ltx_intake.sv
rtl/ltx_fifo.sv
rtl/ltx_tx_io.sv
rtl/ltx_top.sv
sim/ltx_sva.sv
sim/ltx_tb.sv
